/* design/bu_pkg.sv */
package bu_pkg;

  // Data and PC width
  localparam int unsigned BU_XLEN = 32;

  // Operand buffer entries, also the credits the sender holds after reset
  localparam int unsigned BU_DEPTH = 2;

  // Major opcodes handled by the unit
  localparam logic [6:0] BU_OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] BU_OPC_JALR   = 7'b1100111;

  // Branch kind, encoded as funct3 of the B-type format
  // Codes 3'b010 and 3'b011 are reserved
  typedef enum logic [2:0] {
    BU_EQ  = 3'b000,
    BU_NE  = 3'b001,
    BU_LT  = 3'b100,
    BU_GE  = 3'b101,
    BU_LTU = 3'b110,
    BU_GEU = 3'b111
  } bu_cond_e;

  // B-type view of the instruction word
  // Immediate is scattered, bit 0 implied zero
  typedef struct packed {
    logic           imm12;
    logic [5:0]     imm10_5;
    logic [4:0]     rs2;
    logic [4:0]     rs1;
    bu_cond_e       funct3;
    logic [3:0]     imm4_1;
    logic           imm11;
    logic [6:0]     opcode;
  } bu_btype_t;

  // I-type view, used for JALR
  typedef struct packed {
    logic [11:0]    imm11_0;
    logic [4:0]     rs1;
    logic [2:0]     funct3;
    logic [4:0]     rd;
    logic [6:0]     opcode;
  } bu_itype_t;

  // One instruction word, decoded as B-type or I-type
  // Opcode sits in the same bits in both views
  typedef union packed {
    logic [31:0]    raw;
    bu_btype_t      b;
    bu_itype_t      i;
  } bu_instr_u;

  // Operation sent by the issue stage
  typedef struct packed {
    bu_instr_u            instr;
    // Address of the branch itself
    logic [BU_XLEN-1:0]   pc;
    logic [BU_XLEN-1:0]   rs1_value;
    logic [BU_XLEN-1:0]   rs2_value;
    // Front end prediction
    logic                 pred_taken;
    logic [BU_XLEN-1:0]   pred_target;
  } bu_op_t;

  // Resolved branch reported to commit
  typedef struct packed {
    logic                 valid;
    logic                 taken;
    logic                 mispredict;
    // Where fetch should have gone after this branch
    logic [BU_XLEN-1:0]   next_pc;
    // Return address, pc + 4
    logic [BU_XLEN-1:0]   link;
  } bu_res_t;

endpackage

/* design/branch_op_buffer.sv */
`timescale 1ns/1ps

module branch_op_buffer (
  input  logic            clk_i,
  input  logic            rst_n_i,

  // Write side from issue
  input  logic            push_i,
  input  bu_pkg::bu_op_t  push_op_i,

  // Read side toward evaluator and CU
  input  logic            pop_i,
  output logic            head_valid_o,
  output bu_pkg::bu_op_t  head_op_o,

  // One pulse per freed entry
  output logic            credit_o
);

  // Pointer and occupancy types sized from the depth
  typedef logic [$clog2(bu_pkg::BU_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(bu_pkg::BU_DEPTH+1)-1:0] cnt_t;

  // Entry storage
  bu_pkg::bu_op_t mem_q [bu_pkg::BU_DEPTH];

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t count_q;
  logic credit_q;

  logic full;
  logic empty;

  assign full  = (count_q == cnt_t'(bu_pkg::BU_DEPTH));
  assign empty = (count_q == '0);

  // Write data into the slot under the write pointer
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_op_i;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        // Wrap at the last entry
        wr_ptr_q <= (wr_ptr_q == ptr_t'(bu_pkg::BU_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(bu_pkg::BU_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Credit goes back the cycle after the entry leaves
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_i;
    end
  end

  assign head_valid_o = !empty;
  assign head_op_o    = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

  // Sender must never push without a credit
  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full
  );

  // Pop only when something is stored
  a_no_pop_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty
  );

endmodule

/* design/branch_eval.sv */
`timescale 1ns/1ps

module branch_eval (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // Operation at the head of the buffer
  input  bu_pkg::bu_op_t              op_i,
  // Pop strobe, latches the payload
  input  logic                        capture_i,

  // Classification flags for the CU, same cycle as the head
  output logic                        taken_o,
  output logic                        wrong_taken_o,
  output logic                        wrong_target_o,

  // Registered payload, held until the next capture
  output logic [bu_pkg::BU_XLEN-1:0]  next_pc_o,
  output logic [bu_pkg::BU_XLEN-1:0]  link_o
);

  bu_pkg::bu_instr_u          instr;

  logic                       is_jalr;
  logic [bu_pkg::BU_XLEN-1:0] imm_b;
  logic [bu_pkg::BU_XLEN-1:0] imm_i;
  logic [bu_pkg::BU_XLEN-1:0] jalr_sum;
  logic [bu_pkg::BU_XLEN-1:0] target;
  logic [bu_pkg::BU_XLEN-1:0] seq_pc;
  logic [bu_pkg::BU_XLEN-1:0] next_pc_d;
  logic                       cond_true;
  logic                       taken;

  logic [bu_pkg::BU_XLEN-1:0] next_pc_q;
  logic [bu_pkg::BU_XLEN-1:0] link_q;

  assign instr   = op_i.instr;
  assign is_jalr = (instr.i.opcode == bu_pkg::BU_OPC_JALR);

  // B-type offset, sign from imm12, bit 0 always zero
  assign imm_b = {{(bu_pkg::BU_XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};

  // I-type offset, plain sign extension
  assign imm_i = {{(bu_pkg::BU_XLEN-12){instr.i.imm11_0[11]}}, instr.i.imm11_0};

  // Condition on the two register values
  always_comb begin
    cond_true = 1'b0;
    case (instr.b.funct3)
      bu_pkg::BU_EQ:  cond_true = (op_i.rs1_value == op_i.rs2_value);
      bu_pkg::BU_NE:  cond_true = (op_i.rs1_value != op_i.rs2_value);
      // Signed compares
      bu_pkg::BU_LT:  cond_true = ($signed(op_i.rs1_value) <  $signed(op_i.rs2_value));
      bu_pkg::BU_GE:  cond_true = ($signed(op_i.rs1_value) >= $signed(op_i.rs2_value));
      // Unsigned compares
      bu_pkg::BU_LTU: cond_true = (op_i.rs1_value <  op_i.rs2_value);
      bu_pkg::BU_GEU: cond_true = (op_i.rs1_value >= op_i.rs2_value);
      default:        cond_true = 1'b0;
    endcase
  end

  // JALR jumps unconditionally
  assign taken = is_jalr || cond_true;

  // JALR target drops the lowest bit
  assign jalr_sum = op_i.rs1_value + imm_i;
  assign target   = is_jalr ? {jalr_sum[bu_pkg::BU_XLEN-1:1], 1'b0} : op_i.pc + imm_b;

  assign seq_pc    = op_i.pc + bu_pkg::BU_XLEN'(4);
  assign next_pc_d = taken ? target : seq_pc;

  // Compare against the front end guess
  assign taken_o        = taken;
  assign wrong_taken_o  = (taken != op_i.pred_taken);
  assign wrong_target_o = (target != op_i.pred_target);

  // Payload latched on acceptance
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      next_pc_q <= next_pc_d;
      link_q    <= seq_pc;
    end
  end

  assign next_pc_o = next_pc_q;
  assign link_o    = link_q;

  // Only branches and JALR reach this unit
  a_known_opcode: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    capture_i |-> (instr.i.opcode == bu_pkg::BU_OPC_BRANCH ||
                   instr.i.opcode == bu_pkg::BU_OPC_JALR)
  );

endmodule

/* design/branch_unit_cu.sv */
`timescale 1ns/1ps

module branch_unit_cu (
  input  logic clk_i,
  input  logic rst_n_i,

  // Head of the operand buffer and its classification
  input  logic ops_valid_i,
  input  logic taken_i,
  input  logic wrong_taken_i,
  input  logic wrong_target_i,

  // Acceptance and one-cycle result
  output logic ops_ready_o,
  output logic res_valid_o,
  output logic res_taken_o,
  output logic res_mispredict_o
);

  typedef enum logic [2:0] {
    RESET,
    WAIT_OPS,
    GOOD_T,
    GOOD_NT,
    BAD_T,
    BAD_NT
  } state_e;

  state_e state_q;
  state_e state_d;

  // State register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      // Leave reset after one cycle
      RESET: state_d = WAIT_OPS;

      WAIT_OPS: begin
        if (ops_valid_i) begin
          if (taken_i) begin
            // Taken branch is bad on a wrong direction or a wrong target
            state_d = (wrong_taken_i || wrong_target_i) ? BAD_T : GOOD_T;
          end else begin
            // Target is irrelevant when not taken
            state_d = wrong_taken_i ? BAD_NT : GOOD_NT;
          end
        end
      end

      // All result states last one cycle
      GOOD_T, GOOD_NT, BAD_T, BAD_NT: state_d = WAIT_OPS;

      default: state_d = RESET;
    endcase
  end

  // Moore outputs
  always_comb begin
    ops_ready_o      = 1'b0;
    res_valid_o      = 1'b0;
    res_taken_o      = 1'b0;
    res_mispredict_o = 1'b0;
    case (state_q)
      WAIT_OPS: ops_ready_o = 1'b1;
      GOOD_T: begin
        res_valid_o = 1'b1;
        res_taken_o = 1'b1;
      end
      GOOD_NT: res_valid_o = 1'b1;
      BAD_T: begin
        res_valid_o      = 1'b1;
        res_taken_o      = 1'b1;
        res_mispredict_o = 1'b1;
      end
      BAD_NT: begin
        res_valid_o      = 1'b1;
        res_mispredict_o = 1'b1;
      end
      default: ops_ready_o = 1'b0;
    endcase
  end

  // A result is a single pulse
  a_res_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |=> !res_valid_o
  );

  // No acceptance while a result is out
  a_ready_vs_res: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(ops_ready_o && res_valid_o)
  );

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // Issue side, credit flow control
  input  logic             issue_valid_i,
  input  bu_pkg::bu_op_t   issue_op_i,
  output logic             credit_o,

  // Resolved branch toward commit
  output bu_pkg::bu_res_t  res_o
);

  logic                       head_valid;
  bu_pkg::bu_op_t             head_op;
  logic                       pop;

  logic                       taken;
  logic                       wrong_taken;
  logic                       wrong_target;
  logic [bu_pkg::BU_XLEN-1:0] next_pc;
  logic [bu_pkg::BU_XLEN-1:0] link;

  logic                       ops_ready;
  logic                       res_valid;
  logic                       res_taken;
  logic                       res_mispredict;

  // Head leaves the buffer when the CU takes it
  assign pop = ops_ready & head_valid;

  branch_op_buffer buffer_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (issue_valid_i),
    .push_op_i    (issue_op_i),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_op_o    (head_op),
    .credit_o     (credit_o)
  );

  // Evaluator latches its payload on the same pop edge
  branch_eval eval_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .op_i           (head_op),
    .capture_i      (pop),
    .taken_o        (taken),
    .wrong_taken_o  (wrong_taken),
    .wrong_target_o (wrong_target),
    .next_pc_o      (next_pc),
    .link_o         (link)
  );

  branch_unit_cu cu_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ops_valid_i      (head_valid),
    .taken_i          (taken),
    .wrong_taken_i    (wrong_taken),
    .wrong_target_i   (wrong_target),
    .ops_ready_o      (ops_ready),
    .res_valid_o      (res_valid),
    .res_taken_o      (res_taken),
    .res_mispredict_o (res_mispredict)
  );

  // Flags from the CU, addresses from the evaluator
  assign res_o = '{
    valid:      res_valid,
    taken:      res_taken,
    mispredict: res_mispredict,
    next_pc:    next_pc,
    link:       link
  };

endmodule

/* dv/tb_branch_unit.sv */
`timescale 1ns/1ps

module tb_branch_unit;

  logic            clk_i = 1'b0;
  logic            rst_n_i;
  logic            issue_valid_i;
  bu_pkg::bu_op_t  issue_op_i;
  logic            credit_o;
  bu_pkg::bu_res_t res_o;

  // Sender side bookkeeping
  int unsigned     credits;
  int unsigned     issued;
  int unsigned     returned;
  logic            issued_any;
  // Set for the cycle of an issue into an empty unit
  logic            idle_issue;
  // Result seen this cycle is retired at the next edge
  logic            res_seen;
  logic [31:0]     rng_state;

  // In-order scoreboard
  bu_pkg::bu_res_t exp_q[$];
  logic            jalr_q[$];
  bu_pkg::bu_res_t exp_head;
  logic            head_jalr;
  int unsigned     exp_count;

  // Boundary operand pairs for signed and unsigned compares
  logic [31:0] bound_a [6] = '{32'h0, 32'h8000_0000, 32'h1, 32'hFFFF_FFFF,
                               32'h7FFF_FFFF, 32'h0000_0005};
  logic [31:0] bound_b [6] = '{32'h0, 32'h1, 32'h8000_0000, 32'h0,
                               32'h8000_0000, 32'h0000_0005};

  branch_unit branch_unit_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_op_i    (issue_op_i),
    .credit_o      (credit_o),
    .res_o         (res_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    abort_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // xorshift32
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Reference model works on the raw instruction bits
  function automatic logic model_taken(input bu_pkg::bu_op_t op);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    w = op.instr.raw;
    a = op.rs1_value;
    b = op.rs2_value;
    if (w[6:0] == bu_pkg::BU_OPC_JALR) begin
      return 1'b1;
    end
    // Flipping the sign bit turns a signed order into an unsigned one
    case (w[14:12])
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
      3'b101:  return !((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
      3'b110:  return a < b;
      3'b111:  return !(a < b);
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] model_target(input bu_pkg::bu_op_t op);
    logic [31:0] w;
    logic [31:0] sum;
    w = op.instr.raw;
    if (w[6:0] == bu_pkg::BU_OPC_JALR) begin
      sum = op.rs1_value + {{20{w[31]}}, w[31:20]};
      return sum & 32'hFFFF_FFFE;
    end
    return op.pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic bu_pkg::bu_res_t expect_result(input bu_pkg::bu_op_t op);
    bu_pkg::bu_res_t res;
    logic            tk;
    logic [31:0]     tgt;
    tk             = model_taken(op);
    tgt            = model_target(op);
    res.valid      = 1'b1;
    res.taken      = tk;
    // Target only matters when the branch goes
    res.mispredict = (tk != op.pred_taken) || (tk && tgt != op.pred_target);
    res.next_pc    = tk ? tgt : op.pc + 32'd4;
    res.link       = op.pc + 32'd4;
    return res;
  endfunction

  function automatic bu_pkg::bu_cond_e cond_of(input int kind);
    case (kind)
      0:       return bu_pkg::BU_EQ;
      1:       return bu_pkg::BU_NE;
      2:       return bu_pkg::BU_LT;
      3:       return bu_pkg::BU_GE;
      4:       return bu_pkg::BU_LTU;
      default: return bu_pkg::BU_GEU;
    endcase
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = next_random();
    case (r[2:0])
      3'd0:    return 32'h0;
      3'd1:    return 32'h1;
      3'd2:    return 32'hFFFF_FFFF;
      3'd3:    return 32'h8000_0000;
      3'd4:    return 32'h7FFF_FFFF;
      default: return next_random();
    endcase
  endfunction

  // Kind 0 to 5 picks a branch condition and 6 gives JALR
  function automatic bu_pkg::bu_op_t make_op(input int kind, input logic [31:0] a,
                                             input logic [31:0] b);
    bu_pkg::bu_op_t op;
    logic [31:0]    r;
    logic           tk;
    logic [31:0]    tgt;
    op = '0;
    r  = next_random();
    if (kind == 6) begin
      op.instr.i.imm11_0 = r[11:0];
      op.instr.i.rs1     = r[16:12];
      op.instr.i.funct3  = 3'b000;
      op.instr.i.rd      = r[21:17];
      op.instr.i.opcode  = bu_pkg::BU_OPC_JALR;
    end else begin
      op.instr.b.imm12   = r[12];
      op.instr.b.imm11   = r[11];
      op.instr.b.imm10_5 = r[10:5];
      op.instr.b.imm4_1  = r[4:1];
      op.instr.b.rs1     = r[17:13];
      op.instr.b.rs2     = r[22:18];
      op.instr.b.funct3  = cond_of(kind);
      op.instr.b.opcode  = bu_pkg::BU_OPC_BRANCH;
    end
    r            = next_random();
    op.pc        = {r[31:2], 2'b00};
    op.rs1_value = a;
    op.rs2_value = b;
    tk           = model_taken(op);
    tgt          = model_target(op);
    // Half the guesses are right and the rest wrong in direction, target or both
    r              = next_random();
    op.pred_taken  = tk;
    op.pred_target = tgt;
    case (r[1:0])
      2'b10: op.pred_taken = !tk;
      2'b11: begin
        op.pred_target = tgt ^ (32'h4 | {r[31:2], 2'b00});
        op.pred_taken  = r[2] ? !tk : tk;
      end
      default: op.pred_taken = tk;
    endcase
    return op;
  endfunction

  // Advance one cycle and change inputs 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    issue_valid_i = 1'b0;
    idle_issue    = 1'b0;
    if (res_seen) begin
      exp_q.delete(0);
      jalr_q.delete(0);
    end
    res_seen = res_o.valid;
    if (credit_o) begin
      credits++;
      returned++;
    end
    exp_count = exp_q.size();
    if (exp_count > 0) begin
      exp_head  = exp_q[0];
      head_jalr = jalr_q[0];
    end else begin
      exp_head  = '0;
      head_jalr = 1'b0;
    end
  endtask

  task automatic send_op(input bu_pkg::bu_op_t op);
    int unsigned waited;
    waited = 0;
    while (credits == 0) begin
      if (waited == 20) abort_run("Timed out waiting for an issue credit");
      next_cycle();
      waited++;
    end
    idle_issue    = (exp_q.size() == 0);
    issue_valid_i = 1'b1;
    issue_op_i    = op;
    exp_q.push_back(expect_result(op));
    jalr_q.push_back(op.instr.raw[6:0] == bu_pkg::BU_OPC_JALR);
    credits--;
    issued++;
    issued_any = 1'b1;
    next_cycle();
  endtask

  // Wait until every result is out
  task automatic drain_unit();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == 50) abort_run("Timed out waiting for the unit to drain");
      next_cycle();
      waited++;
    end
  endtask

  // Checks sample mid-cycle on the falling edge
  a_quiet_after_reset: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    !issued_any |-> (!res_o.valid && !credit_o))
    else abort_run("Result or credit seen before any issue");

  a_idle_gap: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    $past(idle_issue) |-> !res_o.valid)
    else mismatch("res_o.valid", res_o.valid, 1'b0);

  // Two edges from issue to result when idle
  a_idle_latency: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    $past(idle_issue, 2) |-> res_o.valid)
    else mismatch("res_o.valid", res_o.valid, 1'b1);

  a_idle_credit: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    $past(idle_issue, 2) |-> credit_o)
    else mismatch("credit_o", credit_o, 1'b1);

  a_result_expected: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    res_o.valid |-> exp_count != 0)
    else abort_run("Result appeared with no operation outstanding");

  a_taken: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    res_o.valid |-> res_o.taken == exp_head.taken)
    else mismatch("res_o.taken", res_o.taken, exp_head.taken);

  a_mispredict: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    res_o.valid |-> res_o.mispredict == exp_head.mispredict)
    else mismatch("res_o.mispredict", res_o.mispredict, exp_head.mispredict);

  a_next_pc: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    res_o.valid |-> res_o.next_pc == exp_head.next_pc)
    else mismatch("res_o.next_pc", res_o.next_pc, exp_head.next_pc);

  a_link: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    res_o.valid |-> res_o.link == exp_head.link)
    else mismatch("res_o.link", res_o.link, exp_head.link);

  // JALR lands on an even address
  a_jalr_align: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    (res_o.valid && head_jalr) |-> !res_o.next_pc[0])
    else mismatch("res_o.next_pc", res_o.next_pc, exp_head.next_pc);

  a_credit_bound: assert property (@(negedge clk_i) disable iff (!rst_n_i)
    credits <= bu_pkg::BU_DEPTH)
    else abort_run("Sender holds more credits than the buffer has entries");

  initial begin
    int          kind;
    int          pair;
    int          n;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_op_i    = '0;
    rng_state     = 32'd17196;
    credits       = bu_pkg::BU_DEPTH;
    issued        = 0;
    returned      = 0;
    issued_any    = 1'b0;
    idle_issue    = 1'b0;
    res_seen      = 1'b0;
    exp_head      = '0;
    head_jalr     = 1'b0;
    exp_count     = 0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    // Nothing may come out during the idle stretch
    repeat (6) next_cycle();
    // Each kind against the boundary pairs one at a time into an idle unit
    for (kind = 0; kind < 7; kind++) begin
      for (pair = 0; pair < 6; pair++) begin
        send_op(make_op(kind, bound_a[pair], bound_b[pair]));
        drain_unit();
      end
    end
    // Back to back until credits run out with a gap now and then
    for (n = 0; n < 300; n++) begin
      r = next_random();
      a = pick_operand();
      b = r[3] ? a : pick_operand();
      send_op(make_op(int'(r[31:16] % 16'd7), a, b));
      if (r[5:4] == 2'b00) begin
        next_cycle();
      end
    end
    drain_unit();
    if (returned == issued) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run($sformatf("Returned %0d credits for %0d issues", returned, issued));
    end
  end

endmodule

/* sim.f */
design/bu_pkg.sv
design/branch_op_buffer.sv
design/branch_eval.sv
design/branch_unit_cu.sv
design/branch_unit.sv
dv/tb_branch_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the branch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_branch_unit -f sim.f -o sim_branch_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_branch_unit 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
